// ==== compile.f ====
rtl/mtsp_fmt_pkg.sv
rtl/mtsp_uop_pkg.sv
rtl/mtsp_flfr_ctrl.sv
rtl/mtsp_flfr_operand.sv
rtl/mtsp_flfr_ex0.sv
rtl/mtsp_flfr_ex1.sv
rtl/mtsp_alu_flfr.sv
verification/mtsp_alu_flfr_sva.sv
verification/tb_mtsp_alu_flfr.sv

// ==== verification/tb_mtsp_alu_flfr.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mtsp_alu_flfr
  import mtsp_fmt_pkg::*;
  import mtsp_uop_pkg::*;
();

  // Descriptor encodings {n_en, class, fn}
  localparam logic [UOP_W-1:0] UOP_NOP       = 6'h00;
  localparam logic [UOP_W-1:0] UOP_ADD       = {1'b0, ADD, 1'b0};
  localparam logic [UOP_W-1:0] UOP_FLOOR     = {1'b0, FLFR, FN_FLOOR};
  localparam logic [UOP_W-1:0] UOP_FRACT     = {1'b0, FLFR, FN_FRACT};
  localparam logic [UOP_W-1:0] UOP_FLOOR_OFF = {1'b1, FLFR, FN_FLOOR};

  // One table row, applied in one cycle
  typedef struct {
    logic [UOP_W-1:0]  mo0;
    logic              m0;
    logic [UOP_W-1:0]  mo1;
    logic              m1;
    logic [DATA_W-1:0] s0a;
    logic [DATA_W-1:0] s0b;
    logic [DATA_W-1:0] s1a;
    logic [DATA_W-1:0] s1b;
    logic [1:0]        pe;
    logic [BUS_W-1:0]  dout;
  } row_t;

  logic              clk;
  logic              rst_n;
  logic [UOP_W-1:0]  mo0;
  logic [UOP_W-1:0]  mo1;
  logic              mo0_mask;
  logic              mo1_mask;
  logic [DATA_W-1:0] src0a;
  logic [DATA_W-1:0] src0b;
  logic [DATA_W-1:0] src1a;
  logic [DATA_W-1:0] src1b;
  logic [1:0]        phase_en;
  logic [BUS_W-1:0]  dout;

  row_t              rows[$];
  logic [DATA_W-1:0] held_result;
  int                cycles = 0;
  int                cycle_limit = 0;

  mtsp_alu_flfr i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .mo0      (mo0),
    .mo1      (mo1),
    .mo0_mask (mo0_mask),
    .mo1_mask (mo1_mask),
    .src0a    (src0a),
    .src0b    (src0b),
    .src1a    (src1a),
    .src1b    (src1b),
    .phase_en (phase_en),
    .dout     (dout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================
  // Reference model on integer mantissas
  // ==========================================================
  // Largest integer not above x, re-encoded from its magnitude
  function automatic logic [DATA_W-1:0] floor_ref(input logic [DATA_W-1:0] x);
    int          e;
    int          sh;
    int          p;
    logic [16:0] m;
    logic [16:0] ip;
    logic [16:0] aligned;
    e = int'(x[22:16]);
    m = {1'b1, x[15:0]};
    if (e == 0 || e >= 79) return x;
    if (e < 63) return x[23] ? DATA_NEG_ONE : DATA_ZERO;
    sh = 79 - e;
    ip = m >> sh;
    // Negative with dropped bits rounds the magnitude up
    if (x[23] && ((m & ((17'h1 << sh) - 17'h1)) != 17'h0)) ip = ip + 17'h1;
    p = 0;
    for (int i = 0; i < 17; i++) begin
      if (ip[i]) p = i;
    end
    aligned = ip << (16 - p);
    return {x[23], 7'(63 + p), aligned[15:0]};
  endfunction

  // x - floor(x), value r * 2^-sh, normalized and truncated
  function automatic logic [DATA_W-1:0] fract_ref(input logic [DATA_W-1:0] x);
    int           e;
    int           sh;
    int           p;
    logic [127:0] f;
    logic [127:0] r;
    logic [15:0]  fr;
    e = int'(x[22:16]);
    if (e == 0 || e >= 79) return DATA_ZERO;
    sh = 79 - e;
    f = {111'h0, 1'b1, x[15:0]} & ((128'h1 << sh) - 128'h1);
    if (f == 128'h0) return DATA_ZERO;
    r = x[23] ? (128'h1 << sh) - f : f;
    p = 0;
    for (int i = 0; i < 128; i++) begin
      if (r[i]) p = i;
    end
    if (p >= 16) fr = 16'(r >> (p - 16));
    else fr = 16'(r << (16 - p));
    return {1'b0, 7'(63 + p - sh), fr};
  endfunction

  function automatic logic [DATA_W-1:0] ref_result(input logic fn, input logic [DATA_W-1:0] x);
    return fn ? fract_ref(x) : floor_ref(x);
  endfunction

  // Exponents 48..83 cover small, mixed and integer values
  function automatic logic [DATA_W-1:0] rand_operand();
    logic [6:0] e;
    if ($urandom % 16 == 0) return DATA_ZERO;
    e = 7'(48 + $urandom % 36);
    return {1'($urandom), e, 16'($urandom)};
  endfunction

  // ==========================================================
  // Table construction
  // ==========================================================
  task automatic add_row(input logic [UOP_W-1:0] u0, input logic k0,
                         input logic [UOP_W-1:0] u1, input logic k1,
                         input logic [DATA_W-1:0] a0, input logic [DATA_W-1:0] b0,
                         input logic [DATA_W-1:0] a1, input logic [DATA_W-1:0] b1,
                         input logic [1:0] pe, input logic [DATA_W-1:0] res);
    row_t r;
    r.mo0 = u0;
    r.m0  = k0;
    r.mo1 = u1;
    r.m1  = k1;
    r.s0a = a0;
    r.s0b = b0;
    r.s1a = a1;
    r.s1b = b1;
    // Idle rows show the result of the operand still held
    if (pe != 2'b00) held_result = res;
    r.pe   = pe;
    r.dout = {8'h00, held_result};
    rows.push_back(r);
  endtask

  // Phase 0, source A
  task automatic add_p0(input logic [UOP_W-1:0] u0, input logic [DATA_W-1:0] x,
                        input logic [DATA_W-1:0] res);
    add_row(u0, 1'b0, UOP_NOP, 1'b0, x, 24'h0, 24'h0, 24'h0, 2'b01, res);
  endtask

  task automatic add_random();
    int                sel;
    logic              k0;
    logic              k1;
    logic [UOP_W-1:0]  u0;
    logic [UOP_W-1:0]  u1;
    logic [DATA_W-1:0] s [4];
    logic [DATA_W-1:0] pick;
    sel = int'($urandom % 8);
    k0  = 1'($urandom);
    k1  = 1'($urandom);
    for (int i = 0; i < 4; i++) begin
      s[i] = rand_operand();
    end
    u0 = {1'b0, FLFR, 1'($urandom)};
    u1 = {1'b0, FLFR, 1'($urandom)};
    if (sel < 3) begin
      pick = k0 ? s[1] : s[0];
      add_row(u0, k0, UOP_NOP, k1, s[0], s[1], s[2], s[3], 2'b01, ref_result(u0[0], pick));
    end else if (sel < 7) begin
      // Phase 1 alone, or both with phase 1 winning
      if (sel < 6) u0 = UOP_NOP;
      pick = k1 ? s[3] : s[2];
      add_row(u0, k0, u1, k1, s[0], s[1], s[2], s[3], 2'b10, ref_result(u1[0], pick));
    end else begin
      u0[UOP_NEN_BIT] = 1'b1;
      add_row(u0, k0, UOP_ADD, k1, s[0], s[1], s[2], s[3], 2'b00, 24'h0);
    end
  endtask

  task automatic build_table();
    held_result = DATA_ZERO;
    // Floor over the value ranges
    add_p0(UOP_FLOOR, 24'h404000, 24'h400000);
    add_p0(UOP_FLOOR, 24'hC04000, 24'hC08000);
    add_p0(UOP_FLOOR, 24'h408000, 24'h408000);
    add_p0(UOP_FLOOR, 24'hC10000, 24'hC10000);
    add_p0(UOP_FLOOR, 24'h3E8000, 24'h000000);
    add_p0(UOP_FLOOR, 24'hBE8000, 24'hBF0000);
    add_p0(UOP_FLOOR, 24'h531234, 24'h531234);
    add_p0(UOP_FLOOR, 24'hD31234, 24'hD31234);
    add_p0(UOP_FLOOR, 24'h000000, 24'h000000);
    add_p0(UOP_FLOOR, 24'hBF4000, 24'hC00000);
    // Fraction, positive, negative, leading ones and integers
    add_p0(UOP_FRACT, 24'h404000, 24'h3E0000);
    add_p0(UOP_FRACT, 24'h3F4000, 24'h3D0000);
    add_p0(UOP_FRACT, 24'h3E8000, 24'h3E8000);
    add_p0(UOP_FRACT, 24'hC04000, 24'h3E0000);
    add_p0(UOP_FRACT, 24'hBF4000, 24'h3E8000);
    add_p0(UOP_FRACT, 24'hBD0000, 24'h3E8000);
    add_p0(UOP_FRACT, 24'hBB0000, 24'h3EE000);
    add_p0(UOP_FRACT, 24'h408000, 24'h000000);
    add_p0(UOP_FRACT, 24'h4F0001, 24'h000000);
    add_p0(UOP_FRACT, 24'hC10000, 24'h000000);
    // Source pick and phase priority
    add_row(UOP_FLOOR, 1'b1, UOP_NOP, 1'b0, 24'h404000, 24'hC04000, 24'h408000,
            24'hBE8000, 2'b01, 24'hC08000);
    add_row(UOP_NOP, 1'b0, UOP_FLOOR, 1'b0, 24'h404000, 24'hC04000, 24'h408000,
            24'hBE8000, 2'b10, 24'h408000);
    add_row(UOP_FLOOR, 1'b0, UOP_FLOOR, 1'b1, 24'h404000, 24'hC04000, 24'h408000,
            24'hBE8000, 2'b10, 24'hBF0000);
    add_row(UOP_FRACT, 1'b0, UOP_FLOOR, 1'b0, 24'h404000, 24'hC04000, 24'h408000,
            24'hBE8000, 2'b10, 24'h408000);
    // Disabled and foreign descriptors
    add_row(UOP_FLOOR_OFF, 1'b0, UOP_ADD, 1'b0, 24'h3F4000, 24'h0, 24'h0, 24'h0, 2'b00, 24'h0);
    add_row(UOP_ADD, 1'b0, UOP_FLOOR_OFF, 1'b1, 24'h0, 24'h0, 24'h0, 24'h3F4000, 2'b00, 24'h0);
    add_row(UOP_FLOOR_OFF, 1'b0, UOP_FRACT, 1'b1, 24'h404000, 24'hC04000, 24'h408000,
            24'hBE8000, 2'b10, 24'h3D0000);
    add_row(UOP_NOP, 1'b0, UOP_NOP, 1'b0, 24'h0, 24'h0, 24'h0, 24'h0, 2'b00, 24'h0);
    // Back-to-back random traffic
    for (int i = 0; i < 60; i++) begin
      add_random();
    end
  endtask

  // ==========================================================
  // Drive and check
  // ==========================================================
  task automatic check_value(input string name, input logic [BUS_W-1:0] expected,
                             input logic [BUS_W-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic apply_row(input row_t r);
    mo0      = r.mo0;
    mo0_mask = r.m0;
    mo1      = r.mo1;
    mo1_mask = r.m1;
    src0a    = r.s0a;
    src0b    = r.s0b;
    src1a    = r.s1a;
    src1b    = r.s1b;
  endtask

  // Run limit from table length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(97));
    rst_n    = 1'b0;
    mo0      = UOP_NOP;
    mo1      = UOP_NOP;
    mo0_mask = 1'b0;
    mo1_mask = 1'b0;
    src0a    = '0;
    src0b    = '0;
    src1a    = '0;
    src1b    = '0;
    build_table();
    cycle_limit = rows.size() + 40;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    check_value("phase_en", 32'h0, {30'h0, phase_en});
    check_value("dout", 32'h0, dout);
    // Row i issues now, row i-2 is at the outputs
    for (int i = 0; i < rows.size() + 2; i++) begin
      @(posedge clk);
      #1;
      if (i >= 2) begin
        check_value("phase_en", {30'h0, rows[i-2].pe}, {30'h0, phase_en});
        check_value("dout", rows[i-2].dout, dout);
      end
      if (i < rows.size()) begin
        apply_row(rows[i]);
      end else begin
        mo0 = UOP_NOP;
        mo1 = UOP_NOP;
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/mtsp_alu_flfr_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_alu_flfr_sva
  import mtsp_fmt_pkg::*;
  import mtsp_uop_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input logic [UOP_W-1:0] mo0,
  input logic [UOP_W-1:0] mo1,
  input logic [1:0]       phase_en,
  input logic [BUS_W-1:0] dout
);

  logic flfr_any;

  // Either phase addresses the FLFR unit
  assign flfr_any = (!mo0[UOP_NEN_BIT] && (mo0[UOP_CLS_MSB:UOP_CLS_LSB] == FLFR))
                 || (!mo1[UOP_NEN_BIT] && (mo1[UOP_CLS_MSB:UOP_CLS_LSB] == FLFR));

  // An issued op shows exactly one phase enable two cycles on
  a_phase_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
                                    flfr_any |-> ##2 $onehot(phase_en))
    else $error("phase_en is not one-hot two cycles after an FLFR descriptor");

  // Two idle cycles in a row leave the held result on the bus
  a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                !flfr_any ##1 !flfr_any |-> ##2 $stable(dout))
    else $error("dout changed although no FLFR op was issued");

  // A cycle without an FLFR descriptor clears the phase enable two cycles on
  a_idle_phase: assert property (@(posedge clk) disable iff (!rst_n)
                                 !flfr_any |-> ##2 (phase_en == 2'b00))
    else $error("phase_en set after a cycle without an FLFR descriptor");

endmodule

bind mtsp_alu_flfr mtsp_alu_flfr_sva i_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .mo0      (mo0),
  .mo1      (mo1),
  .phase_en (phase_en),
  .dout     (dout)
);

`default_nettype wire

// ==== rtl/mtsp_alu_flfr.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_alu_flfr
  import mtsp_fmt_pkg::*;
  import mtsp_uop_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [UOP_W-1:0]  mo0,
  input  logic [UOP_W-1:0]  mo1,
  input  logic              mo0_mask,
  input  logic              mo1_mask,
  input  logic [DATA_W-1:0] src0a,
  input  logic [DATA_W-1:0] src0b,
  input  logic [DATA_W-1:0] src1a,
  input  logic [DATA_W-1:0] src1b,
  output logic [1:0]        phase_en,
  output logic [BUS_W-1:0]  dout
);

  // SM stage controls
  logic              load;
  logic              src_phase;
  logic              src_b;
  logic [DATA_W-1:0] din;

  // EX0 to EX1
  logic              ex1_sign;
  logic [EXP_W-1:0]  ex1_exp;
  logic [FRAC_W:0]   ex1_frac_raw;
  logic              ex1_frac_zero;
  logic [DATA_W-1:0] ex1_floor;
  flfr_fn_e          fn_ex1;

  // Decoder and phase tag
  mtsp_flfr_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .mo0       (mo0),
    .mo1       (mo1),
    .mo0_mask  (mo0_mask),
    .mo1_mask  (mo1_mask),
    .load      (load),
    .src_phase (src_phase),
    .src_b     (src_b),
    .fn_ex1    (fn_ex1),
    .phase_en  (phase_en)
  );

  // SM stage operand
  mtsp_flfr_operand u_operand (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .src_phase (src_phase),
    .src_b     (src_b),
    .src0a     (src0a),
    .src0b     (src0b),
    .src1a     (src1a),
    .src1b     (src1b),
    .din       (din)
  );

  // Floor and raw fraction
  mtsp_flfr_ex0 u_ex0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .din           (din),
    .ex1_sign      (ex1_sign),
    .ex1_exp       (ex1_exp),
    .ex1_frac_raw  (ex1_frac_raw),
    .ex1_frac_zero (ex1_frac_zero),
    .ex1_floor     (ex1_floor)
  );

  // Normalize and drive the bus
  mtsp_flfr_ex1 u_ex1 (
    .ex1_sign      (ex1_sign),
    .ex1_exp       (ex1_exp),
    .ex1_frac_raw  (ex1_frac_raw),
    .ex1_frac_zero (ex1_frac_zero),
    .ex1_floor     (ex1_floor),
    .fn_ex1        (fn_ex1),
    .dout          (dout)
  );

endmodule

`default_nettype wire

// ==== rtl/mtsp_flfr_ex1.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_flfr_ex1
  import mtsp_fmt_pkg::*;
  import mtsp_uop_pkg::*;
(
  input  logic              ex1_sign,
  input  logic [EXP_W-1:0]  ex1_exp,
  input  logic [FRAC_W:0]   ex1_frac_raw,
  input  logic              ex1_frac_zero,
  input  logic [DATA_W-1:0] ex1_floor,
  input  flfr_fn_e          fn_ex1,
  output logic [BUS_W-1:0]  dout
);

  logic [4:0]        lead_pos;
  logic [4:0]        norm_shift;
  logic [FRAC_W:0]   norm_mant;
  logic [EXP_W-1:0]  norm_exp;
  logic [EXP_W-1:0]  fill_shift;
  logic [FRAC_W:0]   fill_raw;
  logic [FRAC_W-1:0] fill_frac;
  logic              neg_small;
  logic [DATA_W-1:0] fract_val;
  logic [DATA_W-1:0] result;

  // ==========================================================
  // Normalize
  // ==========================================================
  // Highest set bit of the raw fraction
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i <= FRAC_W; i++) begin
      if (ex1_frac_raw[i]) begin
        lead_pos = 5'(i);
      end
    end
  end

  // Move leading one to the hidden position, exponent follows
  assign norm_shift = 5'(FRAC_W) - lead_pos;
  assign norm_mant  = ex1_frac_raw << norm_shift;
  assign norm_exp   = ex1_exp - EXP_W'(norm_shift);

  // ==========================================================
  // Negative operand below 0.5
  // ==========================================================
  // 1 - |x| lands in (0.5, 1), so the exponent is fixed at 62
  // Bits above the raw fraction are all ones
  assign neg_small  = ex1_sign && (ex1_exp < EXP_FRAC_TOP);
  assign fill_shift = EXP_FRAC_TOP - ex1_exp;
  assign fill_raw   = ex1_frac_raw >> fill_shift;
  assign fill_frac  = fill_raw[FRAC_W-1:0]
                    | ~({FRAC_W{1'b1}} >> (fill_shift - 7'd1));

  // Fraction result is never negative
  always_comb begin
    if (ex1_frac_zero) begin
      fract_val = DATA_ZERO;
    end else if (neg_small) begin
      fract_val = {1'b0, EXP_FRAC_TOP, fill_frac};
    end else begin
      fract_val = {1'b0, norm_exp, norm_mant[FRAC_W-1:0]};
    end
  end

  // Result mux and bus
  assign result = (fn_ex1 == FN_FRACT) ? fract_val : ex1_floor;
  assign dout   = {{(BUS_W-DATA_W){1'b0}}, result};

endmodule

`default_nettype wire

// ==== rtl/mtsp_flfr_ex0.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_flfr_ex0
  import mtsp_fmt_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] din,
  output logic              ex1_sign,
  output logic [EXP_W-1:0]  ex1_exp,
  output logic [FRAC_W:0]   ex1_frac_raw,
  output logic              ex1_frac_zero,
  output logic [DATA_W-1:0] ex1_floor
);

  logic                    sign_v;
  logic [EXP_W-1:0]        exp_v;
  logic [FRAC_W-1:0]       frac_v;
  logic [FRAC_W:0]         mant;
  logic [FRAC_W:0]         frac_mask;
  logic [FRAC_W:0]         frac_raw;
  logic                    is_zero;
  logic                    is_int;
  logic                    is_small;
  logic [EXP_W+FRAC_W-1:0] flr_sum;
  logic [DATA_W-1:0]       floor_val;

  // Field split
  assign sign_v = din[DATA_W-1];
  assign exp_v  = din[DATA_W-2 -: EXP_W];
  assign frac_v = din[FRAC_W-1:0];
  assign mant   = {1'b1, frac_v};

  assign is_zero  = (exp_v == '0);
  assign is_int   = (exp_v >= EXP_INT);
  assign is_small = (exp_v < EXP_BIAS);

  // ==========================================================
  // Fraction mask
  // ==========================================================
  // Bit i of the mantissa is below the binary point when exp < 79 - i
  always_comb begin
    for (int i = 0; i <= FRAC_W; i++) begin
      frac_mask[i] = (int'(exp_v) < int'(EXP_INT) - i);
    end
  end

  // ==========================================================
  // Floor
  // ==========================================================
  // Negative values: push any set fraction bit into the integer part
  // A carry out of the fraction bumps the exponent
  assign flr_sum = {exp_v, frac_v}
                 + (sign_v ? {{EXP_W{1'b0}}, frac_mask[FRAC_W-1:0]} : '0);

  always_comb begin
    if (is_zero || is_int) begin
      floor_val = din;
    end else if (is_small) begin
      // |x| < 1 gives 0 or -1
      floor_val = sign_v ? DATA_NEG_ONE : DATA_ZERO;
    end else begin
      floor_val = {sign_v, flr_sum[EXP_W+FRAC_W-1 -: EXP_W],
                   flr_sum[FRAC_W-1:0] & ~frac_mask[FRAC_W-1:0]};
    end
  end

  // Raw fraction, 1 - f for negative operands
  assign frac_raw = (sign_v ? -mant : mant) & frac_mask;

  // EX0 pipeline register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex1_sign      <= 1'b0;
      ex1_exp       <= '0;
      ex1_frac_raw  <= '0;
      ex1_frac_zero <= 1'b0;
      ex1_floor     <= '0;
    end else begin
      ex1_sign      <= sign_v;
      ex1_exp       <= exp_v;
      ex1_frac_raw  <= frac_raw;
      ex1_frac_zero <= is_zero | is_int | ~|frac_raw;
      ex1_floor     <= floor_val;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mtsp_flfr_operand.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_flfr_operand
  import mtsp_fmt_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  logic              src_phase,
  input  logic              src_b,
  input  logic [DATA_W-1:0] src0a,
  input  logic [DATA_W-1:0] src0b,
  input  logic [DATA_W-1:0] src1a,
  input  logic [DATA_W-1:0] src1b,
  output logic [DATA_W-1:0] din
);

  logic [DATA_W-1:0] src_sel;

  // Four-way source pick: phase, then mask
  always_comb begin
    case ({src_phase, src_b})
      2'b00:   src_sel = src0a;
      2'b01:   src_sel = src0b;
      2'b10:   src_sel = src1a;
      default: src_sel = src1b;
    endcase
  end

  // SM stage operand register
  // Holds when no FLFR op is issued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      din <= '0;
    end else if (load) begin
      din <= src_sel;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mtsp_flfr_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module mtsp_flfr_ctrl
  import mtsp_uop_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [UOP_W-1:0] mo0,
  input  logic [UOP_W-1:0] mo1,
  input  logic             mo0_mask,
  input  logic             mo1_mask,
  output logic             load,
  output logic             src_phase,
  output logic             src_b,
  output flfr_fn_e         fn_ex1,
  output logic [1:0]       phase_en
);

  logic     mo0_en;
  logic     mo1_en;
  logic     mo_en;
  flfr_fn_e fn_next;

  // SM stage tag
  logic     en_sm;
  logic     phase_sm;
  flfr_fn_e fn_sm;

  // Tag aligned with ex1
  logic     en_ex1;
  logic     phase_ex1;

  // ==========================================================
  // Descriptor decode
  // ==========================================================
  // Enabled and addressed to FLFR
  assign mo0_en = !mo0[UOP_NEN_BIT] && (mo0[UOP_CLS_MSB:UOP_CLS_LSB] == FLFR);
  assign mo1_en = !mo1[UOP_NEN_BIT] && (mo1[UOP_CLS_MSB:UOP_CLS_LSB] == FLFR);
  assign mo_en  = mo0_en | mo1_en;

  // Phase 1 wins when both phases issue
  assign load      = mo_en;
  assign src_phase = mo1_en;
  assign src_b     = mo1_en ? mo1_mask : mo0_mask;
  assign fn_next   = flfr_fn_e'(mo1_en ? mo1[UOP_FN_BIT] : mo0[UOP_FN_BIT]);

  // ==========================================================
  // Tag pipeline
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_sm     <= 1'b0;
      phase_sm  <= 1'b0;
      fn_sm     <= FN_FLOOR;
      en_ex1    <= 1'b0;
      phase_ex1 <= 1'b0;
      fn_ex1    <= FN_FLOOR;
    end else begin
      en_sm    <= mo_en;
      phase_sm <= mo1_en;
      // Function follows the held operand when idle
      if (mo_en) begin
        fn_sm <= fn_next;
      end
      en_ex1    <= en_sm;
      phase_ex1 <= phase_sm;
      fn_ex1    <= fn_sm;
    end
  end

  // One-hot phase of the result leaving ex1
  assign phase_en = {en_ex1 & phase_ex1, en_ex1 & ~phase_ex1};

endmodule

`default_nettype wire

// ==== rtl/mtsp_uop_pkg.sv ====
`default_nettype none

// ==========================================================
// Micro-operation descriptor layout and encodings
// ==========================================================
package mtsp_uop_pkg;

  // Descriptor: {n_en, class[3:0], fn}
  localparam int UOP_W       = 6;
  localparam int UOP_NEN_BIT = 5;
  localparam int UOP_CLS_MSB = 4;
  localparam int UOP_CLS_LSB = 1;
  localparam int UOP_FN_BIT  = 0;

  // ALU class field
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,
    MUL   = 4'd2,
    LOGIC = 4'd3,
    FLFR  = 4'd4,
    MOVE  = 4'd5
  } uop_class_e;

  // Function bit of the FLFR class
  typedef enum logic {
    FN_FLOOR = 1'b0,
    FN_FRACT = 1'b1
  } flfr_fn_e;

endpackage

`default_nettype wire

// ==== rtl/mtsp_fmt_pkg.sv ====
`default_nettype none

// ==========================================================
// 24-bit float format: sign, 7-bit exponent, 16-bit fraction
// ==========================================================
package mtsp_fmt_pkg;

  // Field widths
  localparam int DATA_W = 24;
  localparam int BUS_W  = 32;
  localparam int EXP_W  = 7;
  localparam int FRAC_W = 16;

  // Exponent of 1.0
  localparam logic [EXP_W-1:0] EXP_BIAS     = 7'd63;
  // From here up the hidden one and all fraction bits are integer bits
  localparam logic [EXP_W-1:0] EXP_INT      = 7'd79;
  // Exponent of values in [0.5, 1)
  localparam logic [EXP_W-1:0] EXP_FRAC_TOP = 7'd62;

  // Exponent 0 encodes zero, the other fields are ignored
  localparam logic [DATA_W-1:0] DATA_ZERO    = 24'h00_0000;
  // Sign 1, exponent 63, fraction 0
  localparam logic [DATA_W-1:0] DATA_NEG_ONE = {1'b1, 7'd63, 16'h0000};

endpackage

`default_nettype wire
